// File: hdl/video_pkg.sv
/*
 * Shared constants and types for the video output stage.
 * Raster is tiny to keep simulation short; import into module bodies,
 * use scoped names in port lists.
 */
package video_pkg;

    // raster geometry, in pixels and lines
    localparam int H_ACTIVE = 16;   // visible pixels per line
    localparam int H_TOTAL  = 20;   // incl. horizontal blanking
    localparam int V_ACTIVE = 8;    // visible lines per frame
    localparam int V_TOTAL  = 10;   // incl. vertical blanking

    localparam int PXL_DIV = 4;     // clk cycles per pixel enable

    // palette
    localparam int PAL_DEPTH = 32;  // obj entries in the lower half and scroll in the upper

    // pixel enable stages from layer pixel in to color out
    // stage 1 = mux register, stage 2 = palette read register
    localparam int PIPE_LAT = 2;

    typedef logic [4:0] hcnt_t;     // 0..H_TOTAL-1
    typedef logic [3:0] vcnt_t;     // 0..V_TOTAL-1

    // layer pixel, 0 is transparent
    typedef logic [3:0] layer_pxl_t;

    typedef logic [4:0] pal_addr_t;

    // palette entry laid out as bbgggrrr
    typedef logic [7:0] pal_data_t;

    // one expanded color component
    typedef logic [3:0] color_t;

    // active flags travelling down the pixel pipe
    // high = visible
    typedef struct packed {
        logic lhbl;
        logic lvbl;
    } blank_t;

endpackage

// File: hdl/cen_delay.sv
/*
 * Clock-enabled delay line of DEPTH stages.
 * Payload type set by parameter, so one block covers address and blanking.
 */
module cen_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  T     d,
    output T     q
);

    T stage [DEPTH];    // stage 0 takes d

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (cen) begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];     // shift toward q
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

// File: hdl/pal_ram.sv
/*
 * 32 x 8 palette memory.
 * Write any cycle, read register only moves on the pixel enable.
 */
module pal_ram (
    input  logic                 clk,
    input  logic                 cen,
    input  logic                 we,
    input  video_pkg::pal_addr_t waddr,
    input  video_pkg::pal_addr_t raddr,
    input  video_pkg::pal_data_t wdata,
    output video_pkg::pal_data_t q
);
    import video_pkg::*;

    pal_data_t mem [PAL_DEPTH];     // undefined until loaded

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // second pixel pipe stage
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[raddr];
        end
    end

endmodule

// File: hdl/video_timer.sv
/*
 * Pixel clock enable and raster counters.
 * Drives hcnt/vcnt plus the early (pre-pipeline) active flags
 * that feed the color mixer.
 */
module video_timer (
    input  logic                clk,
    input  logic                rst,
    output logic                pxl_cen,
    output video_pkg::hcnt_t    hcnt,
    output video_pkg::vcnt_t    vcnt,
    output logic                pre_lhbl,
    output logic                pre_lvbl
);
    import video_pkg::*;

    localparam int DIV_W = $clog2(PXL_DIV);

    logic [DIV_W-1:0] div;  // clk cycle within the pixel
    logic             h_last;
    logic             v_last;

    // free running clock divider
    always_ff @(posedge clk) begin
        if (rst) begin
            div <= '0;
        end else if (pxl_cen) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    // enable on the last clk of each pixel
    assign pxl_cen = (div == DIV_W'(PXL_DIV - 1));

    assign h_last = (hcnt == hcnt_t'(H_TOTAL - 1));
    assign v_last = (vcnt == vcnt_t'(V_TOTAL - 1));

    // raster counters step on the pixel enable only
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            hcnt <= h_last ? '0 : hcnt + 1'b1;
            if (h_last) begin
                vcnt <= v_last ? '0 : vcnt + 1'b1;  // new line
            end
        end
    end

    // active region is the top left corner of the raster
    assign pre_lhbl = (hcnt < hcnt_t'(H_ACTIVE));
    assign pre_lvbl = (vcnt < vcnt_t'(V_ACTIVE));

endmodule

// File: hdl/pal_loader.sv
/*
 * Palette download FSM.
 * load_start opens a load, then each prog_strobe writes one byte to the
 * next palette address. pal_ready goes high after the last entry.
 */
module pal_loader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_start,
    input  logic                 prog_strobe,
    input  video_pkg::pal_data_t prog_byte,
    output logic                 pal_we,
    output video_pkg::pal_addr_t pal_waddr,
    output video_pkg::pal_data_t pal_wdata,
    output logic                 pal_ready
);
    import video_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        READY
    } state_t;

    state_t    state;
    pal_addr_t addr;        // next address to write
    logic      accept;      // strobe taken this cycle
    logic      last_byte;

    assign accept    = (state == LOAD) && prog_strobe && !load_start;
    assign last_byte = (addr == pal_addr_t'(PAL_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            addr      <= '0;
            pal_we    <= 1'b0;
            pal_ready <= 1'b0;
        end else begin
            pal_we    <= accept;    // write lands one clk after strobe
            pal_ready <= (state == READY) && !load_start;
            if (load_start) begin
                state <= LOAD;      // restart from entry 0 even mid-load
                addr  <= '0;
            end else if (accept) begin
                addr <= addr + 1'b1;
                if (last_byte) begin
                    state <= READY;
                end
            end
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (accept) begin
            pal_waddr <= addr;
            pal_wdata <= prog_byte;
        end
    end

endmodule

// File: hdl/colmix.sv
/*
 * Color mixer. Object over scroll priority, palette lookup,
 * 8 bit to 444 expansion and blanking aligned to the pixel pipe.
 * Latency is PIPE_LAT pixel enables from pixel in to color out.
 */
module colmix (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic                   pre_lhbl,
    input  logic                   pre_lvbl,
    input  logic                   pal_ready,
    input  logic                   pal_we,
    input  video_pkg::layer_pxl_t  obj_pxl,
    input  video_pkg::layer_pxl_t  scr_pxl,
    input  logic [3:0]             gfx_en,      // bit 3 obj, bit 0 scroll
    input  video_pkg::pal_addr_t   pal_waddr,
    input  video_pkg::pal_data_t   pal_wdata,
    output video_pkg::color_t      red,
    output video_pkg::color_t      green,
    output video_pkg::color_t      blue,
    output logic                   lhbl,
    output logic                   lvbl
);
    import video_pkg::*;

    logic       obj_blank;
    layer_pxl_t scr_gated;
    pal_addr_t  mux_addr;   // combinational palette address
    pal_addr_t  rd_addr;    // after stage 1
    pal_data_t  rgb;        // after stage 2
    blank_t     blank_in;
    blank_t     blank_out;
    logic       show;

    // obj disabled reads as transparent
    assign obj_blank = (obj_pxl == '0) || !gfx_en[3];
    assign scr_gated = gfx_en[0] ? scr_pxl : '0;    // scroll off gives entry 16

    // lower half for objects, upper half for scroll
    assign mux_addr = obj_blank ? {1'b1, scr_gated} : {1'b0, obj_pxl};

    cen_delay #(
        .T     (pal_addr_t),
        .DEPTH (PIPE_LAT - 1)
    ) addr_dly (
        .clk (clk),
        .rst (rst),
        .cen (pxl_cen),
        .d   (mux_addr),
        .q   (rd_addr)
    );

    pal_ram pal (
        .clk   (clk),
        .cen   (pxl_cen),
        .we    (pal_we),
        .waddr (pal_waddr),
        .raddr (rd_addr),
        .wdata (pal_wdata),
        .q     (rgb)
    );

    // active flags go the full pipe length
    assign blank_in = '{lhbl: pre_lhbl, lvbl: pre_lvbl};

    cen_delay #(
        .T     (blank_t),
        .DEPTH (PIPE_LAT)
    ) blank_dly (
        .clk (clk),
        .rst (rst),
        .cen (pxl_cen),
        .d   (blank_in),
        .q   (blank_out)
    );

    assign lhbl = blank_out.lhbl;
    assign lvbl = blank_out.lvbl;

    // black in blanking and before the palette is in
    assign show = lhbl && lvbl && pal_ready;

    // repeat the msbs to fill 4 bits
    assign red   = show ? {rgb[2:0], rgb[2]} : '0;
    assign green = show ? {rgb[5:3], rgb[5]} : '0;
    assign blue  = show ? {2{rgb[7:6]}}      : '0;

endmodule

// File: hdl/video_top.sv
/*
 * Video output stage top.
 * Timer and palette loader feed the color mixer; pixels and the
 * palette byte stream come straight from the ports.
 */
module video_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_start,
    input  logic                  prog_strobe,
    input  video_pkg::pal_data_t  prog_byte,
    input  video_pkg::layer_pxl_t obj_pxl,
    input  video_pkg::layer_pxl_t scr_pxl,
    input  logic [3:0]            gfx_en,
    output logic                  pxl_cen,
    output video_pkg::hcnt_t      hcnt,
    output video_pkg::vcnt_t      vcnt,
    output logic                  pal_ready,
    output logic                  lhbl,
    output logic                  lvbl,
    output video_pkg::color_t     red,
    output video_pkg::color_t     green,
    output video_pkg::color_t     blue
);
    import video_pkg::*;

    logic      pre_lhbl;
    logic      pre_lvbl;
    logic      pal_we;      // loader to palette
    pal_addr_t pal_waddr;
    pal_data_t pal_wdata;

    video_timer timer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hcnt     (hcnt),
        .vcnt     (vcnt),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl)
    );

    pal_loader loader (
        .clk         (clk),
        .rst         (rst),
        .load_start  (load_start),
        .prog_strobe (prog_strobe),
        .prog_byte   (prog_byte),
        .pal_we      (pal_we),
        .pal_waddr   (pal_waddr),
        .pal_wdata   (pal_wdata),
        .pal_ready   (pal_ready)
    );

    colmix mixer (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pre_lhbl  (pre_lhbl),
        .pre_lvbl  (pre_lvbl),
        .pal_ready (pal_ready),
        .pal_we    (pal_we),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .gfx_en    (gfx_en),
        .pal_waddr (pal_waddr),
        .pal_wdata (pal_wdata),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl      (lhbl),
        .lvbl      (lvbl)
    );

endmodule

// File: testbench/video_checker.sv
/*
 * Concurrent assertions for the video stage.
 * Bound into the top level and watches loader and mixer wires.
 */
module video_checker (
    input logic              clk,
    input logic              rst,
    input logic              pxl_cen,
    input logic              load_start,
    input logic              prog_strobe,
    input logic              pal_we,
    input logic              pal_ready,
    input logic              lhbl,
    input video_pkg::color_t red,
    input video_pkg::color_t green,
    input video_pkg::color_t blue
);

    int fail_cnt = 0;   // failed assertions so far

    // enable is a single clk pulse
    cen_pulse: assert property (@(posedge clk) disable iff (rst) pxl_cen |=> !pxl_cen)
        else begin
            $error("pixel enable high for two clocks in a row");
            fail_cnt++;
        end

    // write only after a strobe taken while loading, not on a restart
    we_after_strobe: assert property (@(posedge clk) disable iff (rst)
        pal_we |-> $past(prog_strobe && !load_start && !pal_ready))
        else begin
            $error("palette write without an accepted strobe");
            fail_cnt++;
        end

    black_in_hblank: assert property (@(posedge clk) disable iff (rst)
        !lhbl |-> (red == '0 && green == '0 && blue == '0))
        else begin
            $error("color not black during horizontal blanking");
            fail_cnt++;
        end

endmodule

bind video_top video_checker checker_inst (
    .clk         (clk),
    .rst         (rst),
    .pxl_cen     (pxl_cen),
    .load_start  (load_start),
    .prog_strobe (prog_strobe),
    .pal_we      (pal_we),
    .pal_ready   (pal_ready),
    .lhbl        (lhbl),
    .red         (red),
    .green       (green),
    .blue        (blue)
);

// File: testbench/video_tb.sv
/*
 * Testbench for the video output stage.
 * Palette bytes and pixel vectors come from the testdata file. A cycle model
 * of loader, raster and mixer predicts every output on the falling edge.
 */
module video_tb;
    import video_pkg::*;

    localparam int NVEC   = 40;                         // pixel vectors in the file
    localparam int NDATA  = 2 * PAL_DEPTH + NVEC;       // two palettes followed by vectors
    localparam int PERIOD = 40;
    localparam int FRAME  = H_TOTAL * V_TOTAL * PXL_DIV; // clks per frame
    // twice the reset, two loads and five frames of pixels
    localparam int TIMEOUT = 2 * PERIOD * (10 + 2 * PAL_DEPTH * PXL_DIV + 5 * FRAME);

    logic       clk = 1'b0;
    logic       rst;
    logic       load_start;
    logic       prog_strobe;
    pal_data_t  prog_byte;
    layer_pxl_t obj_pxl;
    layer_pxl_t scr_pxl;
    logic [3:0] gfx_en;
    logic       pxl_cen;
    hcnt_t      hcnt;
    vcnt_t      vcnt;
    logic       pal_ready;
    logic       lhbl;
    logic       lvbl;
    color_t     red;
    color_t     green;
    color_t     blue;

    logic [11:0] tdata [NDATA];     // palette bytes followed by {gfx_en, obj, scr}
    pal_data_t   m_pal [PAL_DEPTH]; // model palette
    logic        m_valid [PAL_DEPTH];
    pal_addr_t   h_addr [2];        // [0] newest enable snapshot
    logic        h_act_h [2];
    logic        h_act_v [2];
    pal_data_t   exp_q;             // model of the palette read register
    logic        exp_q_ok;          // read hit a written entry
    logic        exp_lh;
    logic        exp_lv;
    hcnt_t       m_h;
    vcnt_t       m_v;
    logic        m_load;            // loader in LOAD
    logic        m_done;            // loader in READY
    logic        m_ready;
    pal_addr_t   m_addr;
    logic        wr_v;              // write pending for next clk
    pal_addr_t   wr_a;
    pal_data_t   wr_d;
    logic        cen_seen;          // the edge just passed was an enable
    int          gap;
    int          vidx;
    int          seed;
    int          mismatches;
    int          failures;

    always #(PERIOD / 2) clk = ~clk;

    video_top video_top_inst (
        .clk         (clk),
        .rst         (rst),
        .load_start  (load_start),
        .prog_strobe (prog_strobe),
        .prog_byte   (prog_byte),
        .obj_pxl     (obj_pxl),
        .scr_pxl     (scr_pxl),
        .gfx_en      (gfx_en),
        .pxl_cen     (pxl_cen),
        .hcnt        (hcnt),
        .vcnt        (vcnt),
        .pal_ready   (pal_ready),
        .lhbl        (lhbl),
        .lvbl        (lvbl),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

    // object wins unless transparent or disabled
    function automatic pal_addr_t pick_addr(input logic [11:0] v);
        if (v[11] && v[7:4] != 4'h0) begin
            return {1'b0, v[7:4]};
        end
        return {1'b1, v[8] ? v[3:0] : 4'h0};    // scroll off means entry 16
    endfunction

    function automatic color_t widen3(input logic [2:0] c);
        return {c, c[2]};       // msb copied into the lsb
    endfunction

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic next_vector();
        int idx;
        if (vidx < NVEC) begin
            idx = vidx;
        end else begin
            idx = ($random(seed) & 32'h7fff_ffff) % NVEC;   // replay file vectors
        end
        vidx++;
        {gfx_en, obj_pxl, scr_pxl} = tdata[2 * PAL_DEPTH + idx];
    endtask

    // advance the model one clk past the rising edge, compare and drive
    task automatic tick();
        logic acc;
        logic show;
        @(negedge clk);
        if (cen_seen) begin
            exp_q    = m_pal[h_addr[1]];      // read sees memory before this edge's write
            exp_q_ok = m_valid[h_addr[1]];
            exp_lh   = h_act_h[1];
            exp_lv   = h_act_v[1];
            if (int'(m_h) == H_TOTAL - 1) begin
                m_h = '0;
                m_v = (int'(m_v) == V_TOTAL - 1) ? '0 : m_v + 4'd1;
            end else begin
                m_h = m_h + 5'd1;
            end
        end
        if (wr_v) begin
            m_pal[wr_a]   = wr_d;
            m_valid[wr_a] = 1'b1;
        end
        // loader model sees the inputs as they stood at the edge
        acc     = m_load && prog_strobe && !load_start;
        wr_v    = acc;
        wr_a    = m_addr;
        wr_d    = prog_byte;
        m_ready = m_done && !load_start;
        if (load_start) begin
            m_load = 1'b1;
            m_done = 1'b0;
            m_addr = '0;
        end else if (acc) begin
            if (int'(m_addr) == PAL_DEPTH - 1) begin
                m_load = 1'b0;
                m_done = 1'b1;
            end
            m_addr = m_addr + 5'd1;
        end
        check("hcnt", 8'(hcnt), 8'(m_h));
        check("vcnt", 8'(vcnt), 8'(m_v));
        check("pal_ready", 8'(pal_ready), 8'(m_ready));
        check("lhbl", 8'(lhbl), 8'(exp_lh));
        check("lvbl", 8'(lvbl), 8'(exp_lv));
        show = m_ready && exp_lh && exp_lv;
        if (!show || exp_q_ok) begin     // unwritten entry, nothing to predict
            check("red", 8'(red), 8'(show ? widen3(exp_q[2:0]) : 4'h0));
            check("green", 8'(green), 8'(show ? widen3(exp_q[5:3]) : 4'h0));
            check("blue", 8'(blue), 8'(show ? {2{exp_q[7:6]}} : 4'h0));
        end
        gap++;
        if (pxl_cen) begin
            assert (gap == PXL_DIV) else begin
                $display("t=%0t pixel enable came %0d clks after the last one", $time, gap);
                failures++;
            end
            gap = 0;
        end else begin
            assert (gap < PXL_DIV) else begin
                $display("t=%0t pixel enable missing", $time);
                failures++;
            end
        end
        if (cen_seen) begin
            next_vector();      // new pixel right after each enable
        end
        if (pxl_cen) begin
            h_addr[1]  = h_addr[0];
            h_act_h[1] = h_act_h[0];
            h_act_v[1] = h_act_v[0];
            h_addr[0]  = pick_addr({gfx_en, obj_pxl, scr_pxl});
            h_act_h[0] = int'(m_h) < H_ACTIVE;
            h_act_v[0] = int'(m_v) < V_ACTIVE;
        end
        cen_seen = pxl_cen;
    endtask

    // one byte every PXL_DIV clks
    task automatic load_palette(input int base);
        load_start = 1'b1;
        tick();
        load_start = 1'b0;
        for (int i = 0; i < PAL_DEPTH; i++) begin
            prog_strobe = 1'b1;
            prog_byte   = tdata[base + i][7:0];
            tick();
            prog_strobe = 1'b0;
            repeat (PXL_DIV - 1) tick();
        end
        repeat (2) tick();
        assert (pal_ready) else begin
            $display("t=%0t palette not ready after the last byte", $time);
            failures++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        load_start  = 1'b0;
        prog_strobe = 1'b0;
        prog_byte   = '0;
        obj_pxl     = '0;
        scr_pxl     = '0;
        gfx_en      = '0;
        seed        = 92997;
        mismatches  = 0;
        failures    = 0;
        vidx        = 0;
        gap         = 1;        // rst release counts as the first clk
        cen_seen    = 1'b0;
        m_h         = '0;
        m_v         = '0;
        m_load      = 1'b0;
        m_done      = 1'b0;
        m_ready     = 1'b0;
        m_addr      = '0;
        wr_v        = 1'b0;
        wr_a        = '0;
        wr_d        = '0;
        exp_q       = '0;
        exp_q_ok    = 1'b0;
        exp_lh      = 1'b0;
        exp_lv      = 1'b0;
        for (int i = 0; i < 2; i++) begin
            h_addr[i]  = '0;
            h_act_h[i] = 1'b0;
            h_act_v[i] = 1'b0;
        end
        for (int i = 0; i < PAL_DEPTH; i++) begin
            m_pal[i]   = '0;
            m_valid[i] = 1'b0;
        end
        $readmemh("testbench/video_testdata.txt", tdata);
        repeat (10) @(negedge clk);
        rst = 1'b0;
        next_vector();
        repeat (FRAME) tick();          // empty palette gives all black
        load_palette(0);
        repeat (2 * FRAME) tick();
        // stray strobe in READY is ignored
        prog_strobe = 1'b1;
        prog_byte   = 8'h00;
        tick();
        prog_strobe = 1'b0;
        repeat (FRAME / 2) tick();
        load_palette(PAL_DEPTH);        // reload drops pal_ready meanwhile
        repeat (FRAME) tick();
        $display("done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatches, failures, video_top_inst.checker_inst.fail_cnt);
        if (mismatches == 0 && failures == 0 &&
            video_top_inst.checker_inst.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("timeout: run still going after %0d time units", TIMEOUT);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: testbench/video_testdata.txt
// words 0..31 first palette, 32..63 reload palette (bbgggrrr bytes)
// words 64..103 pixel vectors, hex digits gfx_en, obj_pxl, scr_pxl
1c ff aa 55 0f f0 92 49 24 db b6 6d 07 38 c0 e3
00 3f f8 c7 81 7e 13 ec 5a a5 66 99 33 cc 01 80
ff 00 55 aa f0 0f 6d b6 db 24 49 92 f8 c7 3f 1c
e3 c0 38 07 7e 81 ec 13 a5 5a 99 66 cc 33 80 01
// opaque objects, both layers on
910 920 930 940 950 960 970 980
990 9a0 9b0 9c0 9d0 9e0 9f0 901
// transparent objects over scroll
902 903 904 905 906 907 908 90f
// layer enables
835 8f1 1a5 1f2 80a 807 900 0c3
9a9 aa9 b3c 196 d55 e00 f77 64e

// File: src.f
hdl/video_pkg.sv
hdl/cen_delay.sv
hdl/pal_ram.sv
hdl/video_timer.sv
hdl/pal_loader.sv
hdl/colmix.sv
hdl/video_top.sv
testbench/video_checker.sv
testbench/video_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = video_tb
FLIST = src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
